//--- Bender.yml
package:
  name: ethernet_stream

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/stream_pkg.sv
      - rtl/word_fifo.sv
      - rtl/packet_receiver.sv
      - rtl/packet_sender.sv
      - rtl/ethernet_stream_top.sv
  - target: test
    include_dirs:
      - rtl
      - verif
    files:
      - verif/tb_ethernet_stream.sv

//--- project.f
+incdir+rtl
+incdir+verif
rtl/stream_pkg.sv
rtl/word_fifo.sv
rtl/packet_receiver.sv
rtl/packet_sender.sv
rtl/ethernet_stream_top.sv
verif/tb_ethernet_stream.sv

//--- rtl/ethernet_stream_top.sv
`timescale 1ns/10ps
`include "stream_settings.svh"

module ethernet_stream_top
(
	input logic GMII_GTX_CLK_int,
	input logic rst_i,

	// ADC samples
	input stream_pkg::sample_t adc_data_i,
	input logic adc_we_i,

	// Receive stream
	input stream_pkg::stream_word_t rx_i,
	input logic rx_src_rdy_i,
	output logic rx_dst_rdy_o,

	// Transmit stream
	output stream_pkg::stream_word_t tx_o,
	output logic tx_src_rdy_o,
	input logic tx_dst_rdy_i
);

	import stream_pkg::*;

	sample_t cfg_wr_data;
	sample_t cfg_head;
	sample_t adc_head;
	logic cfg_wr;
	logic cfg_full;
	logic cfg_avail;
	logic cfg_rd;
	logic adc_avail;
	logic adc_rd;

	////////////////////
	// Sample FIFO
	////////////////////
	word_fifo #(
		.ADDR_W(`ADC_FIFO_AW),
		.LEVEL(`ADC_PACKET_WORDS)
	) i_adc_fifo (
		.GMII_GTX_CLK_int(GMII_GTX_CLK_int),
		.rst_i(rst_i),
		.wr_i(adc_we_i),
		.din_i(adc_data_i),
		.rd_i(adc_rd),
		.dout_o(adc_head),
		.full_o(),
		.empty_o(),
		.pkt_avail_o(adc_avail)
	);

	////////////////////
	// Receive side
	////////////////////
	packet_receiver i_receiver (
		.GMII_GTX_CLK_int(GMII_GTX_CLK_int),
		.rst_i(rst_i),
		.rx_i(rx_i),
		.rx_src_rdy_i(rx_src_rdy_i),
		.rx_dst_rdy_o(rx_dst_rdy_o),
		.cfg_full_i(cfg_full),
		.cfg_wr_o(cfg_wr),
		.cfg_data_o(cfg_wr_data)
	);

	// Configuration payload waiting to go back out
	word_fifo #(
		.ADDR_W(`CFG_FIFO_AW),
		.LEVEL(`CFG_PACKET_WORDS)
	) i_cfg_fifo (
		.GMII_GTX_CLK_int(GMII_GTX_CLK_int),
		.rst_i(rst_i),
		.wr_i(cfg_wr),
		.din_i(cfg_wr_data),
		.rd_i(cfg_rd),
		.dout_o(cfg_head),
		.full_o(cfg_full),
		.empty_o(),
		.pkt_avail_o(cfg_avail)
	);

	////////////////////
	// Transmit side
	////////////////////
	packet_sender i_sender (
		.GMII_GTX_CLK_int(GMII_GTX_CLK_int),
		.rst_i(rst_i),
		.cfg_head_i(cfg_head),
		.cfg_avail_i(cfg_avail),
		.cfg_rd_o(cfg_rd),
		.adc_head_i(adc_head),
		.adc_avail_i(adc_avail),
		.adc_rd_o(adc_rd),
		.tx_o(tx_o),
		.tx_src_rdy_o(tx_src_rdy_o),
		.tx_dst_rdy_i(tx_dst_rdy_i)
	);

endmodule

//--- rtl/packet_receiver.sv
`timescale 1ns/10ps
`include "stream_settings.svh"

module packet_receiver
(
	input logic GMII_GTX_CLK_int,
	input logic rst_i,

	// Receive stream from the MAC
	input stream_pkg::stream_word_t rx_i,
	input logic rx_src_rdy_i,
	output logic rx_dst_rdy_o,

	// Write side of the configuration FIFO
	input logic cfg_full_i,
	output logic cfg_wr_o,
	output stream_pkg::sample_t cfg_data_o
);

	import stream_pkg::*;

	packet_len_t hdr_cnt;
	packet_len_t hdr_eff;
	logic in_frame;
	logic accept;
	logic payload;

	// Stall the MAC while the FIFO is full
	assign rx_dst_rdy_o = ~cfg_full_i;
	assign accept = rx_src_rdy_i & rx_dst_rdy_o;

	// Header words still to drop, counting the current word
	assign hdr_eff = rx_i.flags.sof ? packet_len_t'(`RX_HEADER_WORDS) : hdr_cnt;

	// Payload runs from the end of the header up to and including eof
	assign payload = accept & (rx_i.flags.sof | in_frame) & (hdr_eff == '0);

	////////////////////
	// Frame tracking
	////////////////////
	always_ff @(posedge GMII_GTX_CLK_int)
	begin
		if (rst_i)
		begin
			hdr_cnt <= '0;
			in_frame <= 1'b0;
			cfg_wr_o <= 1'b0;
		end
		else
		begin
			cfg_wr_o <= payload;
			if (accept)
			begin
				if (hdr_eff != '0)
					hdr_cnt <= hdr_eff - 1'b1;
				else
					hdr_cnt <= '0;

				if (rx_i.flags.eof)
					in_frame <= 1'b0;
				else if (rx_i.flags.sof)
					in_frame <= 1'b1;
			end
		end
	end

	// Payload word goes out one cycle after it was accepted
	always_ff @(posedge GMII_GTX_CLK_int)
	begin
		if (payload)
			cfg_data_o <= rx_i.data;
	end

endmodule

//--- rtl/packet_sender.sv
`timescale 1ns/10ps
`include "stream_settings.svh"

module packet_sender
(
	input logic GMII_GTX_CLK_int,
	input logic rst_i,

	// Primary source, configuration data
	input stream_pkg::sample_t cfg_head_i,
	input logic cfg_avail_i,
	output logic cfg_rd_o,

	// Secondary source, ADC samples
	input stream_pkg::sample_t adc_head_i,
	input logic adc_avail_i,
	output logic adc_rd_o,

	// Transmit stream to the MAC
	output stream_pkg::stream_word_t tx_o,
	output logic tx_src_rdy_o,
	input logic tx_dst_rdy_i
);

	import stream_pkg::*;

	localparam packet_len_t CFG_LEN = packet_len_t'(`CFG_PACKET_WORDS);
	localparam packet_len_t ADC_LEN = packet_len_t'(`ADC_PACKET_WORDS);

	sender_state_e state;
	packet_len_t word_cnt;
	packet_len_t pkt_len;
	sample_t head;
	logic xfer;
	logic last;

	assign tx_src_rdy_o = (state != SEND_IDLE);
	assign xfer = tx_src_rdy_o & tx_dst_rdy_i;
	assign last = (word_cnt == packet_len_t'(1));

	////////////////////
	// Source select
	////////////////////
	always_comb
	begin
		case (state)
			SEND_CFG:
			begin
				head = cfg_head_i;
				pkt_len = CFG_LEN;
			end
			SEND_ADC:
			begin
				head = adc_head_i;
				pkt_len = ADC_LEN;
			end
			default:
			begin
				head = '0;
				pkt_len = '0;
			end
		endcase
	end

	// Counter starts full, so sof marks the first word
	always_comb
	begin
		tx_o = '0;
		if (tx_src_rdy_o)
		begin
			tx_o.data = head;
			tx_o.flags.sof = (word_cnt == pkt_len);
			tx_o.flags.eof = last;
		end
	end

	// Pop only on an accepted word
	assign cfg_rd_o = xfer & (state == SEND_CFG);
	assign adc_rd_o = xfer & (state == SEND_ADC);

	////////////////////
	// Packet FSM
	////////////////////
	always_ff @(posedge GMII_GTX_CLK_int)
	begin
		if (rst_i)
		begin
			state <= SEND_IDLE;
			word_cnt <= '0;
		end
		else
		begin
			case (state)
				SEND_IDLE:
				begin
					// Configuration first
					if (cfg_avail_i)
					begin
						state <= SEND_CFG;
						word_cnt <= CFG_LEN;
					end
					else if (adc_avail_i)
					begin
						state <= SEND_ADC;
						word_cnt <= ADC_LEN;
					end
				end
				SEND_CFG, SEND_ADC:
				begin
					if (xfer)
					begin
						word_cnt <= word_cnt - 1'b1;
						// One idle cycle between packets
						if (last)
							state <= SEND_IDLE;
					end
				end
				default:
				begin
					state <= SEND_IDLE;
				end
			endcase
		end
	end

endmodule

//--- rtl/stream_pkg.sv
`include "stream_settings.svh"

package stream_pkg;

	// One sample or payload word
	typedef logic [`STREAM_DATA_W-1:0] sample_t;

	// Flag nibble in front of every stream word
	typedef struct packed
	{
		logic [`STREAM_FLAGS_W-3:0] rsvd;
		logic eof;
		logic sof;
	} stream_flags_t;

	// Flags sit above the data, as on the 36-bit MAC stream
	typedef struct packed
	{
		stream_flags_t flags;
		sample_t data;
	} stream_word_t;

	// Word counts and FIFO fill levels
	typedef logic [9:0] packet_len_t;

	// Packet sender states
	typedef enum logic [1:0]
	{
		SEND_IDLE,
		SEND_CFG,
		SEND_ADC
	} sender_state_e;

endpackage

//--- rtl/stream_settings.svh
`ifndef STREAM_SETTINGS_SVH
`define STREAM_SETTINGS_SVH

////////////////////
// Stream word layout
////////////////////
`define STREAM_DATA_W 32
`define STREAM_FLAGS_W 4

////////////////////
// FIFO sizes
////////////////////
// Sample FIFO holds 512 words
`define ADC_FIFO_AW 9
// Configuration FIFO holds 64 words
`define CFG_FIFO_AW 6

////////////////////
// Packet framing
////////////////////
`define ADC_PACKET_WORDS 16
`define CFG_PACKET_WORDS 4
// Leading words of each received frame that carry no payload
`define RX_HEADER_WORDS 2

`endif

//--- rtl/word_fifo.sv
`timescale 1ns/10ps

module word_fifo #(
	parameter int unsigned ADDR_W = 6,
	parameter int unsigned LEVEL = 4
)
(
	input logic GMII_GTX_CLK_int,
	input logic rst_i,

	// Write side
	input logic wr_i,
	input stream_pkg::sample_t din_i,

	// Read side, head word shown without delay
	input logic rd_i,
	output stream_pkg::sample_t dout_o,

	output logic full_o,
	output logic empty_o,
	output logic pkt_avail_o
);

	import stream_pkg::*;

	localparam int unsigned DEPTH = 1 << ADDR_W;

	sample_t mem [DEPTH];
	logic [ADDR_W-1:0] wr_ptr;
	logic [ADDR_W-1:0] rd_ptr;
	packet_len_t count;
	packet_len_t count_next;
	logic wr_ok;
	logic rd_ok;

	assign full_o = (count == packet_len_t'(DEPTH));
	assign empty_o = (count == '0);

	// Writes into a full FIFO are dropped
	assign wr_ok = wr_i & ~full_o;
	assign rd_ok = rd_i & ~empty_o;

	// First word fall through
	assign dout_o = mem[rd_ptr];

	always_comb
	begin
		count_next = count;
		if (wr_ok & ~rd_ok)
			count_next = count + 1'b1;
		else if (rd_ok & ~wr_ok)
			count_next = count - 1'b1;
	end

	always_ff @(posedge GMII_GTX_CLK_int)
	begin
		if (wr_ok)
			mem[wr_ptr] <= din_i;
	end

	////////////////////
	// Pointers and fill level
	////////////////////
	always_ff @(posedge GMII_GTX_CLK_int)
	begin
		if (rst_i)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			pkt_avail_o <= 1'b0;
		end
		else
		begin
			if (wr_ok)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd_ok)
				rd_ptr <= rd_ptr + 1'b1;
			count <= count_next;
			// Compared against the next count so a write shows up right after its edge
			pkt_avail_o <= (count_next >= packet_len_t'(LEVEL));
		end
	end

endmodule

//--- verif/tb_tasks.svh
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

// Right-shifting Galois LFSR
localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;
logic [31:0] lfsr_state = 32'd24;

// Samples and payload words written but not yet framed
sample_t sample_q[$];
sample_t payload_q[$];
stream_word_t exp_q[$];

function automatic logic [31:0] lfsr_bits(input int n);
	logic [31:0] v;
	v = '0;
	for (int i = 0; i < n; i++)
	begin
		v = {v[30:0], lfsr_state[0]};
		if (lfsr_state[0])
			lfsr_state = (lfsr_state >> 1) ^ LFSR_TAPS;
		else
			lfsr_state = lfsr_state >> 1;
	end
	return v;
endfunction

function automatic stream_word_t make_word(input sample_t d, input logic sof, input logic eof);
	stream_word_t w;
	w = '0;
	w.data = d;
	w.flags.sof = sof;
	w.flags.eof = eof;
	return w;
endfunction

// Inputs change 1 ns after the rising edge
task automatic step();
	@(posedge GMII_GTX_CLK_int);
	#1;
endtask

task automatic write_samples(input int n);
	sample_t d;
	for (int i = 0; i < n; i++)
	begin
		d = lfsr_bits(32);
		adc_data_i = d;
		adc_we_i = 1'b1;
		sample_q.push_back(d);
		step();
	end
	adc_we_i = 1'b0;
endtask

// Header words then payload with sof first and eof last
task automatic send_frame(input int payload_words);
	int total;
	int t;
	total = `RX_HEADER_WORDS + payload_words;
	for (int w = 0; w < total; w++)
	begin
		rx_i = '0;
		rx_i.flags.sof = (w == 0);
		rx_i.flags.eof = (w == total - 1);
		if (w < `RX_HEADER_WORDS)
			rx_i.data = 32'hABCD_0000 | w;
		else
		begin
			rx_i.data = lfsr_bits(32);
			payload_q.push_back(rx_i.data);
		end
		rx_src_rdy_i = 1'b1;
		t = 0;
		while (!rx_dst_rdy_o && t < 200)
		begin
			step();
			t++;
		end
		assert (rx_dst_rdy_o) else
		begin
			err_timeout++;
			$display("Receive stream stayed stalled for %0d cycles at word %0d", t, w);
		end
		step();
	end
	rx_src_rdy_i = 1'b0;
endtask

task automatic queue_packet(input bit from_cfg);
	int n;
	sample_t d;
	n = from_cfg ? `CFG_PACKET_WORDS : `ADC_PACKET_WORDS;
	for (int i = 0; i < n; i++)
	begin
		if (from_cfg)
			d = payload_q.pop_front();
		else
			d = sample_q.pop_front();
		exp_q.push_back(make_word(d, i == 0, i == n - 1));
	end
endtask

task automatic wait_tx_words(input int n, input int limit);
	int t;
	t = 0;
	while (got_q.size() < n && t < limit)
	begin
		step();
		t++;
	end
	assert (got_q.size() >= n) else
	begin
		err_timeout++;
		$display("Timed out after %0d cycles waiting for %0d tx words, %0d arrived",
			t, n, got_q.size());
	end
endtask

// Waits for the expected words, lets the line settle, then compares
task automatic check_tx(input int limit);
	int n;
	wait_tx_words(exp_q.size(), limit);
	repeat (20) step();
	assert (got_q.size() == exp_q.size()) else
	begin
		err_value++;
		$display("[ERROR] tx word count: expected %h, got %h", exp_q.size(), got_q.size());
	end
	n = (got_q.size() < exp_q.size()) ? got_q.size() : exp_q.size();
	for (int i = 0; i < n; i++)
	begin
		assert (got_q[i] === exp_q[i]) else
		begin
			err_value++;
			$display("[ERROR] tx_o word %0d: expected %h, got %h", i, exp_q[i], got_q[i]);
		end
	end
	got_q.delete();
	exp_q.delete();
endtask

////////////////////
// Directed tests
////////////////////
task automatic test_reset_state();
	$display("Test: reset state");
	assert (tx_src_rdy_o === 1'b0) else
	begin
		err_value++;
		$display("[ERROR] tx_src_rdy_o: expected %h, got %h", 1'b0, tx_src_rdy_o);
	end
	assert (rx_dst_rdy_o === 1'b1) else
	begin
		err_value++;
		$display("[ERROR] rx_dst_rdy_o: expected %h, got %h", 1'b1, rx_dst_rdy_o);
	end
	// One short of a packet
	write_samples(15);
	repeat (100) step();
	assert (got_q.size() == 0) else
	begin
		err_value++;
		$display("[ERROR] tx word count: expected %h, got %h", 0, got_q.size());
	end
	got_q.delete();
endtask

task automatic test_adc_framing();
	$display("Test: ADC packet framing");
	write_samples(16);
	queue_packet(1'b0);
	check_tx(200);
endtask

task automatic test_receive_echo();
	$display("Test: receive echo");
	send_frame(`CFG_PACKET_WORDS);
	queue_packet(1'b1);
	check_tx(200);
endtask

task automatic test_priority();
	$display("Test: configuration priority");
	tx_dst_rdy_i = 1'b0;
	write_samples(32);
	assert (tx_src_rdy_o === 1'b1) else
	begin
		err_value++;
		$display("[ERROR] tx_src_rdy_o: expected %h, got %h", 1'b1, tx_src_rdy_o);
	end
	send_frame(`CFG_PACKET_WORDS);
	repeat (4) step();
	tx_dst_rdy_i = 1'b1;
	queue_packet(1'b0);
	queue_packet(1'b1);
	queue_packet(1'b0);
	check_tx(400);
endtask

task automatic test_back_pressure();
	int i;
	int t;
	logic [31:0] bits;
	$display("Test: back-pressure");
	i = 0;
	t = 0;
	// Samples and ready bits share the LFSR
	while ((i < 48 || got_q.size() < 48) && t < 3000)
	begin
		if (i < 48)
		begin
			adc_data_i = lfsr_bits(32);
			adc_we_i = 1'b1;
			sample_q.push_back(adc_data_i);
			i++;
		end
		else
			adc_we_i = 1'b0;
		bits = lfsr_bits(1);
		tx_dst_rdy_i = bits[0];
		step();
		t++;
	end
	assert (i == 48 && got_q.size() >= 48) else
	begin
		err_timeout++;
		$display("Timed out after %0d cycles of random back-pressure, %0d tx words arrived",
			t, got_q.size());
	end
	adc_we_i = 1'b0;
	tx_dst_rdy_i = 1'b1;
	repeat (3) queue_packet(1'b0);
	check_tx(400);
endtask

`endif

//--- verif/tb_ethernet_stream.sv
`timescale 1ns/10ps
`include "stream_settings.svh"

module tb_ethernet_stream;

	import stream_pkg::*;

	logic GMII_GTX_CLK_int;
	logic rst_i;
	sample_t adc_data_i;
	logic adc_we_i;
	stream_word_t rx_i;
	logic rx_src_rdy_i;
	logic rx_dst_rdy_o;
	stream_word_t tx_o;
	logic tx_src_rdy_o;
	logic tx_dst_rdy_i;

	// Every word accepted on the transmit stream
	stream_word_t got_q[$];
	int err_value = 0;
	int err_timeout = 0;

	// Word offered but not taken on the previous edge
	logic tx_stalled = 1'b0;
	stream_word_t tx_held;

	`include "tb_tasks.svh"

	ethernet_stream_top i_dut (
		.GMII_GTX_CLK_int(GMII_GTX_CLK_int),
		.rst_i(rst_i),
		.adc_data_i(adc_data_i),
		.adc_we_i(adc_we_i),
		.rx_i(rx_i),
		.rx_src_rdy_i(rx_src_rdy_i),
		.rx_dst_rdy_o(rx_dst_rdy_o),
		.tx_o(tx_o),
		.tx_src_rdy_o(tx_src_rdy_o),
		.tx_dst_rdy_i(tx_dst_rdy_i)
	);

	initial
	begin
		GMII_GTX_CLK_int = 1'b0;
		forever #2 GMII_GTX_CLK_int = ~GMII_GTX_CLK_int;
	end

	////////////////////
	// Transmit monitor
	////////////////////
	always @(posedge GMII_GTX_CLK_int)
	begin
		if (!rst_i && tx_src_rdy_o && tx_dst_rdy_i)
			got_q.push_back(tx_o);
		// A stalled word stays on the bus until it is taken
		if (!rst_i && tx_stalled)
		begin
			assert (tx_src_rdy_o === 1'b1 && tx_o === tx_held) else
			begin
				err_value++;
				$display("[ERROR] tx_o held word: expected %h, got %h", tx_held, tx_o);
			end
		end
		tx_stalled = !rst_i && tx_src_rdy_o && !tx_dst_rdy_i;
		tx_held = tx_o;
	end

	initial
	begin
		rst_i = 1'b1;
		adc_data_i = '0;
		adc_we_i = 1'b0;
		rx_i = '0;
		rx_src_rdy_i = 1'b0;
		tx_dst_rdy_i = 1'b1;
		repeat (16) @(posedge GMII_GTX_CLK_int);
		#1 rst_i = 1'b0;

		test_reset_state();
		test_adc_framing();
		test_receive_echo();
		test_priority();
		test_back_pressure();

		$display("Checks done: %0d value errors, %0d timeouts", err_value, err_timeout);
		if (err_value + err_timeout == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule
